//--- common/fft_defs.svh
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

// ************************************************************
// frame geometry
// ************************************************************

`define FFT_BIT_WIDTH 16 // per real or imaginary part
`define FFT_SIZE      8
`define FFT_STAGES    3  // log2 of FFT_SIZE

// ************************************************************
// twiddle format
// ************************************************************

// Q1.15, so one fraction bit less than the sample width
`define FFT_TW_FRAC   15

`endif

//--- common/fft_pkg.sv
`default_nettype none

`include "fft_defs.svh"

package fft_pkg;

  typedef logic signed [`FFT_BIT_WIDTH-1:0] sample_t;
  typedef logic [`FFT_STAGES-1:0]           idx_t;

  typedef enum logic {LD_FILL, LD_FULL} ld_state_e;
  typedef enum logic {SER_IDLE, SER_SEND} ser_state_e;

  // how b is rotated inside a butterfly
  typedef enum logic [1:0] {
    TW_ONE,   // W^0, pass through
    TW_NEG_J, // W^2, swap and negate
    TW_MUL    // W^1 and W^3, true multiply
  } tw_kind_e;

  // W^k = exp(-j*2*pi*k/8) in Q1.15
  localparam sample_t tw_re_tab [`FFT_SIZE/2] = '{
    16'sh7fff, 16'sh5a82, 16'sh0000, 16'sha57e
  };
  localparam sample_t tw_im_tab [`FFT_SIZE/2] = '{
    16'sh0000, 16'sha57e, 16'sh8000, 16'sha57e
  };

  function automatic tw_kind_e tw_kind_of(input int unsigned k);
    if (k == 0)
      return TW_ONE;
    else if (k == `FFT_SIZE / 4)
      return TW_NEG_J;
    else
      return TW_MUL;
  endfunction

  function automatic idx_t bit_rev(input idx_t i);
    idx_t r;
    for (int b = 0; b < `FFT_STAGES; b++) begin
      r[b] = i[`FFT_STAGES-1-b];
    end
    return r;
  endfunction

  // lower point index of butterfly pair p at a given stage
  function automatic int pair_lo(input int stage, input int p);
    int span;
    span = 1 << stage;
    return (p / span) * 2 * span + (p % span);
  endfunction

endpackage

`default_nettype wire

//--- fft/fft_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_defs.svh"

module fft_crossbar #(
  parameter int STAGE = 0,
  parameter bit FRONT = 1
) (
  input  fft_pkg::sample_t in_re  [`FFT_SIZE],
  input  fft_pkg::sample_t in_im  [`FFT_SIZE],
  input  logic             in_val,
  output logic             in_rdy,

  output fft_pkg::sample_t out_re [`FFT_SIZE],
  output fft_pkg::sample_t out_im [`FFT_SIZE],
  output logic             out_val,
  input  logic             out_rdy
);

  localparam int NPAIR = `FFT_SIZE / 2;
  localparam int SPAN  = 1 << STAGE; // distance between pair members

  // ************************************************************
  // fixed permutation
  // ************************************************************

  for (genvar i = 0; i < NPAIR; i++) begin : g_pair
    localparam int LO = ((i / SPAN) * 2 * SPAN) + (i % SPAN);
    localparam int HI = LO + SPAN;

    if (FRONT) begin : g_fwd
      // natural order -> lanes 2i, 2i+1
      assign out_re[2*i]   = in_re[LO];
      assign out_im[2*i]   = in_im[LO];
      assign out_re[2*i+1] = in_re[HI];
      assign out_im[2*i+1] = in_im[HI];
    end else begin : g_inv
      assign out_re[LO] = in_re[2*i];
      assign out_im[LO] = in_im[2*i];
      assign out_re[HI] = in_re[2*i+1];
      assign out_im[HI] = in_im[2*i+1];
    end
  end

  // handshake passes straight through
  assign out_val = in_val;
  assign in_rdy  = out_rdy;

endmodule

`default_nettype wire

//--- fft/fft_butterfly_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_defs.svh"

module fft_butterfly_stage #(
  parameter int STAGE = 0
) (
  input  logic             clk,
  input  logic             rst_n,

  input  fft_pkg::sample_t in_re  [`FFT_SIZE],
  input  fft_pkg::sample_t in_im  [`FFT_SIZE],
  input  logic             in_val,
  output logic             in_rdy,

  output fft_pkg::sample_t out_re [`FFT_SIZE],
  output fft_pkg::sample_t out_im [`FFT_SIZE],
  output logic             out_val,
  input  logic             out_rdy
);

  import fft_pkg::*;

  localparam int NPAIR = `FFT_SIZE / 2;
  localparam int SPAN  = 1 << STAGE;
  localparam int EW    = `FFT_BIT_WIDTH + 2;     // butterfly sum width
  localparam int PW    = 2 * `FFT_BIT_WIDTH + 2; // complex product width

  sample_t bf_re [`FFT_SIZE];
  sample_t bf_im [`FFT_SIZE];
  logic    load;

  // ************************************************************
  // butterflies
  // ************************************************************

  for (genvar i = 0; i < NPAIR; i++) begin : g_bfly
    localparam int       LO   = pair_lo(STAGE, i);
    localparam int       TW   = (LO % SPAN) * (NPAIR / SPAN);
    localparam tw_kind_e KIND = tw_kind_of(TW);

    logic signed [PW-1:0] prod_re;
    logic signed [PW-1:0] prod_im;
    logic signed [EW-1:0] bw_re;
    logic signed [EW-1:0] bw_im;
    logic signed [EW-1:0] sum_re;
    logic signed [EW-1:0] sum_im;
    logic signed [EW-1:0] dif_re;
    logic signed [EW-1:0] dif_im;

    always_comb begin
      prod_re = PW'(in_re[2*i+1]) * PW'(tw_re_tab[TW])
              - PW'(in_im[2*i+1]) * PW'(tw_im_tab[TW]);
      prod_im = PW'(in_re[2*i+1]) * PW'(tw_im_tab[TW])
              + PW'(in_im[2*i+1]) * PW'(tw_re_tab[TW]);
      case (KIND)
        TW_ONE: begin
          bw_re = EW'(in_re[2*i+1]);
          bw_im = EW'(in_im[2*i+1]);
        end
        TW_NEG_J: begin // (x + jy) * -j = y - jx
          bw_re = EW'(in_im[2*i+1]);
          bw_im = -EW'(in_re[2*i+1]);
        end
        default: begin
          bw_re = EW'(prod_re >>> `FFT_TW_FRAC); // truncate
          bw_im = EW'(prod_im >>> `FFT_TW_FRAC);
        end
      endcase
      sum_re = EW'(in_re[2*i]) + bw_re;
      sum_im = EW'(in_im[2*i]) + bw_im;
      dif_re = EW'(in_re[2*i]) - bw_re;
      dif_im = EW'(in_im[2*i]) - bw_im;
    end

    // halve each output against growth
    assign bf_re[2*i]   = sample_t'(sum_re >>> 1);
    assign bf_im[2*i]   = sample_t'(sum_im >>> 1);
    assign bf_re[2*i+1] = sample_t'(dif_re >>> 1);
    assign bf_im[2*i+1] = sample_t'(dif_im >>> 1);
  end

  // ************************************************************
  // elastic pipeline register
  // ************************************************************

  assign load   = !out_val || out_rdy; // empty or draining
  assign in_rdy = load;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_val <= 1'b0;
    end else if (load) begin
      out_val <= in_val;
    end
  end

  always_ff @(posedge clk) begin
    if (load && in_val) begin
      out_re <= bf_re;
      out_im <= bf_im;
    end
  end

endmodule

`default_nettype wire

//--- fft/fft_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_defs.svh"

module fft_core (
  input  logic             clk,
  input  logic             rst_n,

  input  fft_pkg::sample_t ld_re [`FFT_SIZE],
  input  fft_pkg::sample_t ld_im [`FFT_SIZE],
  input  logic             ld_val,
  output logic             ld_rdy,

  output fft_pkg::sample_t fr_re [`FFT_SIZE],
  output fft_pkg::sample_t fr_im [`FFT_SIZE],
  output logic             fr_val,
  input  logic             fr_rdy
);

  import fft_pkg::*;

  // stage boundaries, index 0 is the loader side
  sample_t                st_re [`FFT_STAGES+1][`FFT_SIZE];
  sample_t                st_im [`FFT_STAGES+1][`FFT_SIZE];
  logic [`FFT_STAGES:0]   st_val;
  logic [`FFT_STAGES:0]   st_rdy;

  assign st_re[0]  = ld_re;
  assign st_im[0]  = ld_im;
  assign st_val[0] = ld_val;
  assign ld_rdy    = st_rdy[0];

  for (genvar s = 0; s < `FFT_STAGES; s++) begin : g_stage
    sample_t xf_re [`FFT_SIZE]; // pair-ordered lanes
    sample_t xf_im [`FFT_SIZE];
    sample_t bo_re [`FFT_SIZE];
    sample_t bo_im [`FFT_SIZE];
    logic    xf_val;
    logic    xf_rdy;
    logic    bo_val;
    logic    bo_rdy;

    fft_crossbar #(.STAGE(s), .FRONT(1'b1)) u_xbar_front (
      .in_re  (st_re[s]),   .in_im  (st_im[s]),
      .in_val (st_val[s]),  .in_rdy (st_rdy[s]),
      .out_re (xf_re),      .out_im (xf_im),
      .out_val(xf_val),     .out_rdy(xf_rdy)
    );

    fft_butterfly_stage #(.STAGE(s)) u_bfly (
      .clk    (clk),        .rst_n  (rst_n),
      .in_re  (xf_re),      .in_im  (xf_im),
      .in_val (xf_val),     .in_rdy (xf_rdy),
      .out_re (bo_re),      .out_im (bo_im),
      .out_val(bo_val),     .out_rdy(bo_rdy)
    );

    fft_crossbar #(.STAGE(s), .FRONT(1'b0)) u_xbar_back (
      .in_re  (bo_re),        .in_im  (bo_im),
      .in_val (bo_val),       .in_rdy (bo_rdy),
      .out_re (st_re[s+1]),   .out_im (st_im[s+1]),
      .out_val(st_val[s+1]),  .out_rdy(st_rdy[s+1])
    );
  end

  assign fr_re                = st_re[`FFT_STAGES];
  assign fr_im                = st_im[`FFT_STAGES];
  assign fr_val               = st_val[`FFT_STAGES];
  assign st_rdy[`FFT_STAGES]  = fr_rdy;

endmodule

`default_nettype wire

//--- logic/bit_reverse_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_defs.svh"

module bit_reverse_loader (
  input  logic             clk,
  input  logic             rst_n,

  input  fft_pkg::sample_t in_re,
  input  fft_pkg::sample_t in_im,
  input  logic             in_val,
  output logic             in_rdy,

  output fft_pkg::sample_t ld_re [`FFT_SIZE],
  output fft_pkg::sample_t ld_im [`FFT_SIZE],
  output logic             ld_val,
  input  logic             ld_rdy
);

  import fft_pkg::*;

  ld_state_e state;
  idx_t      cnt;  // next sample number in the frame
  logic      take;

  assign in_rdy = (state == LD_FILL);
  assign ld_val = (state == LD_FULL);
  assign take   = in_val && in_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= LD_FILL;
      cnt   <= '0;
    end else begin
      case (state)
        LD_FILL: begin
          if (take) begin
            cnt <= cnt + 1'b1; // wraps to 0 after the last one
            if (cnt == idx_t'(`FFT_SIZE - 1))
              state <= LD_FULL;
          end
        end
        LD_FULL: begin
          if (ld_rdy)
            state <= LD_FILL;
        end
        default: state <= LD_FILL;
      endcase
    end
  end

  // sample k lands in slot bit_rev(k)
  always_ff @(posedge clk) begin
    if (take) begin
      ld_re[bit_rev(cnt)] <= in_re;
      ld_im[bit_rev(cnt)] <= in_im;
    end
  end

endmodule

`default_nettype wire

//--- logic/frame_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_defs.svh"

module frame_serializer (
  input  logic             clk,
  input  logic             rst_n,

  input  fft_pkg::sample_t fr_re [`FFT_SIZE],
  input  fft_pkg::sample_t fr_im [`FFT_SIZE],
  input  logic             fr_val,
  output logic             fr_rdy,

  output fft_pkg::sample_t out_re,
  output fft_pkg::sample_t out_im,
  output logic             out_last,
  output logic             out_val,
  input  logic             out_rdy
);

  import fft_pkg::*;

  ser_state_e state;
  idx_t       ptr;
  sample_t    buf_re [`FFT_SIZE];
  sample_t    buf_im [`FFT_SIZE];
  logic       at_end;
  logic       fill;

  assign at_end   = (ptr == idx_t'(`FFT_SIZE - 1));
  assign out_val  = (state == SER_SEND);
  assign out_last = at_end; // ptr only reaches the end while sending
  assign out_re   = buf_re[ptr];
  assign out_im   = buf_im[ptr];

  // refill on the same edge the last bin goes out
  assign fr_rdy = (state == SER_IDLE) || (out_last && out_rdy);
  assign fill   = fr_val && fr_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= SER_IDLE;
      ptr   <= '0;
    end else if (fill) begin
      state <= SER_SEND;
      ptr   <= '0;
    end else if (out_val && out_rdy) begin
      ptr <= ptr + 1'b1;
      if (at_end)
        state <= SER_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      buf_re <= fr_re;
      buf_im <= fr_im;
    end
  end

endmodule

`default_nettype wire

//--- logic/fft_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_defs.svh"

module fft_top (
  input  logic             clk,
  input  logic             rst_n,

  input  fft_pkg::sample_t in_re,
  input  fft_pkg::sample_t in_im,
  input  logic             in_val,
  output logic             in_rdy,

  output fft_pkg::sample_t out_re,
  output fft_pkg::sample_t out_im,
  output logic             out_last,
  output logic             out_val,
  input  logic             out_rdy
);

  import fft_pkg::*;

  // ************************************************************
  // loader -> core -> serializer
  // ************************************************************

  sample_t ld_re [`FFT_SIZE]; // bit-reversed frame
  sample_t ld_im [`FFT_SIZE];
  logic    ld_val;
  logic    ld_rdy;

  sample_t fr_re [`FFT_SIZE]; // bins, natural order
  sample_t fr_im [`FFT_SIZE];
  logic    fr_val;
  logic    fr_rdy;

  bit_reverse_loader u_loader (
    .clk   (clk),    .rst_n (rst_n),
    .in_re (in_re),  .in_im (in_im),
    .in_val(in_val), .in_rdy(in_rdy),
    .ld_re (ld_re),  .ld_im (ld_im),
    .ld_val(ld_val), .ld_rdy(ld_rdy)
  );

  fft_core u_core (
    .clk   (clk),    .rst_n (rst_n),
    .ld_re (ld_re),  .ld_im (ld_im),
    .ld_val(ld_val), .ld_rdy(ld_rdy),
    .fr_re (fr_re),  .fr_im (fr_im),
    .fr_val(fr_val), .fr_rdy(fr_rdy)
  );

  frame_serializer u_serializer (
    .clk     (clk),      .rst_n  (rst_n),
    .fr_re   (fr_re),    .fr_im  (fr_im),
    .fr_val  (fr_val),   .fr_rdy (fr_rdy),
    .out_re  (out_re),   .out_im (out_im),
    .out_last(out_last), .out_val(out_val),
    .out_rdy (out_rdy)
  );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 100, // ns
  parameter int RESET_CYCLES = 5,
  parameter int RELEASE_DLY  = 10   // same offset as the stimulus
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(RELEASE_DLY);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/fft_top_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fft_top_assert (
  input logic             clk,
  input logic             rst_n,
  input fft_pkg::sample_t out_re,
  input fft_pkg::sample_t out_im,
  input logic             out_last,
  input logic             out_val,
  input logic             out_rdy
);

  // ************************************************************
  // output handshake
  // ************************************************************

  // stalled output holds still until taken
  property p_out_hold;
    @(posedge clk) disable iff (!rst_n)
      out_val && !out_rdy |=> out_val && $stable(out_re) && $stable(out_im)
                              && $stable(out_last);
  endproperty

  a_out_hold: assert property (p_out_hold)
    else $error("out_val dropped or output changed while out_rdy was low");

  a_last_val: assert property (@(posedge clk) disable iff (!rst_n) out_last |-> out_val)
    else $error("out_last high without out_val");

  // sync reset, so out_val is low one edge later
  a_rst_val: assert property (@(posedge clk) !rst_n |=> !out_val)
    else $error("out_val high during reset");

endmodule

bind fft_top fft_top_assert u_fft_top_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .out_re  (out_re),
  .out_im  (out_im),
  .out_last(out_last),
  .out_val (out_val),
  .out_rdy (out_rdy)
);

`default_nettype wire

//--- bench/tb_fft_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_defs.svh"

module tb_fft_top;

  import fft_pkg::*;

  localparam int     N        = `FFT_SIZE;
  localparam int     W        = `FFT_BIT_WIDTH;
  localparam int     NROWS    = 7;
  localparam int     DLY      = 10; // ns after the rising edge
  localparam int     LATENCY  = 5;
  localparam int     WATCHDOG = NROWS * 40 + 200;
  localparam longint C45      = 'h5a82; // 0.7071 in Q1.15

  typedef logic [N*W-1:0] frame_t; // bin 0 in the low bits

  logic    clk;
  logic    rst_n;
  sample_t in_re;
  sample_t in_im;
  logic    in_val;
  logic    in_rdy;
  sample_t out_re;
  sample_t out_im;
  logic    out_last;
  logic    out_val;
  logic    out_rdy;

  frame_t      tab_in_re  [NROWS];
  frame_t      tab_in_im  [NROWS];
  frame_t      tab_exp_re [NROWS];
  frame_t      tab_exp_im [NROWS];
  bit          tab_stall  [NROWS];
  int          nrows;
  int          first_stall;
  int          last_in_cycle [NROWS];
  int          out_frame;
  int          cycle = 0;
  int          sample_errors;
  int          last_errors;
  int          other_errors;
  logic [31:0] lfsr;

  tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(5), .RELEASE_DLY(DLY)) u_clk_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  fft_top u_dut (
    .clk     (clk),      .rst_n  (rst_n),
    .in_re   (in_re),    .in_im  (in_im),
    .in_val  (in_val),   .in_rdy (in_rdy),
    .out_re  (out_re),   .out_im (out_im),
    .out_last(out_last), .out_val(out_val),
    .out_rdy (out_rdy)
  );

  always @(posedge clk) cycle <= cycle + 1;

  // Fibonacci, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // 12-bit parts keep every stage clear of overflow
  function automatic sample_t rand_part();
    logic [11:0] v;
    for (int b = 0; b < 12; b++) begin
      v[b] = lfsr_bit();
    end
    return sample_t'($signed(v));
  endfunction

  // ************************************************************
  // reference model, radix-2 DIT with per-stage halving
  // ************************************************************

  task automatic reference_fft(input frame_t in_r, input frame_t in_i,
                               output frame_t ex_r, output frame_t ex_i);
    longint     xr [N];
    longint     xi [N];
    longint     ar, ai, br, bi, tr, ti;
    int         span;
    int         hi;
    int         k;
    logic [2:0] rn;
    for (int n = 0; n < N; n++) begin
      rn = 3'(n);
      xr[{rn[0], rn[1], rn[2]}] = sample_t'(in_r[W*n +: W]);
      xi[{rn[0], rn[1], rn[2]}] = sample_t'(in_i[W*n +: W]);
    end
    for (int s = 0; s < `FFT_STAGES; s++) begin
      span = 1 << s;
      for (int lo = 0; lo < N; lo++) begin
        if ((lo & span) == 0) begin
          hi = lo + span;
          k  = (lo % span) * (N / 2 / span);
          ar = xr[lo];
          ai = xi[lo];
          br = xr[hi];
          bi = xi[hi];
          case (k)
            0: begin
              tr = br;
              ti = bi;
            end
            1: begin // 0.7071 - j0.7071
              tr = (br * C45 + bi * C45) >>> `FFT_TW_FRAC;
              ti = (bi * C45 - br * C45) >>> `FFT_TW_FRAC;
            end
            2: begin // -j
              tr = bi;
              ti = -br;
            end
            default: begin // -0.7071 - j0.7071
              tr = (bi * C45 - br * C45) >>> `FFT_TW_FRAC;
              ti = (-br * C45 - bi * C45) >>> `FFT_TW_FRAC;
            end
          endcase
          xr[lo] = (ar + tr) >>> 1;
          xi[lo] = (ai + ti) >>> 1;
          xr[hi] = (ar - tr) >>> 1;
          xi[hi] = (ai - ti) >>> 1;
        end
      end
    end
    for (int n = 0; n < N; n++) begin
      ex_r[W*n +: W] = xr[n][W-1:0];
      ex_i[W*n +: W] = xi[n][W-1:0];
    end
  endtask

  // ************************************************************
  // table of frames
  // ************************************************************

  task automatic add_row(input frame_t ir, input frame_t ii, input frame_t er,
                         input frame_t ei, input bit stall);
    tab_in_re[nrows]  = ir;
    tab_in_im[nrows]  = ii;
    tab_exp_re[nrows] = er;
    tab_exp_im[nrows] = ei;
    tab_stall[nrows]  = stall;
    if (stall && first_stall == NROWS)
      first_stall = nrows;
    nrows++;
  endtask

  task automatic build_table();
    frame_t rr;
    frame_t ri;
    frame_t er;
    frame_t ei;
    nrows       = 0;
    first_stall = NROWS;
    lfsr        = 32'hf892b513;
    // impulse, every bin gets 1/8
    add_row(128'h0000_0000_0000_0000_0000_0000_0000_0800, '0,
            128'h0100_0100_0100_0100_0100_0100_0100_0100, '0, 1'b0);
    add_row(128'h0800_0800_0800_0800_0800_0800_0800_0800, '0,
            128'h0000_0000_0000_0000_0000_0000_0000_0800, '0, 1'b0);
    add_row(128'hf800_0800_f800_0800_f800_0800_f800_0800, '0,
            128'h0000_0000_0000_0800_0000_0000_0000_0000, '0, 1'b0);
    // 0x0800 * j^k, tone at bin 2
    add_row(128'h0000_f800_0000_0800_0000_f800_0000_0800,
            128'hf800_0000_0800_0000_f800_0000_0800_0000,
            128'h0000_0000_0000_0000_0000_0800_0000_0000, '0, 1'b0);
    for (int n = 0; n < N; n++) begin
      rr[W*n +: W] = rand_part();
      ri[W*n +: W] = rand_part();
    end
    reference_fft(rr, ri, er, ei);
    add_row(rr, ri, er, ei, 1'b1);
    // repeats under random back-pressure
    add_row(tab_in_re[0], tab_in_im[0], tab_exp_re[0], tab_exp_im[0], 1'b1);
    add_row(tab_in_re[3], tab_in_im[3], tab_exp_re[3], tab_exp_im[3], 1'b1);
  endtask

  // ************************************************************
  // checks
  // ************************************************************

  task automatic check_sample(input int frame, input int bin,
                              input sample_t got_re, input sample_t got_im,
                              input sample_t exp_re, input sample_t exp_im);
    if (got_re !== exp_re) begin
      sample_errors++;
      $display("Mismatch frame %0d bin %0d out_re: got %h, expected %h",
               frame, bin, got_re, exp_re);
    end
    if (got_im !== exp_im) begin
      sample_errors++;
      $display("Mismatch frame %0d bin %0d out_im: got %h, expected %h",
               frame, bin, got_im, exp_im);
    end
  endtask

  task automatic check_last(input int frame, input int bin, input logic got,
                            input logic expected);
    if (got !== expected) begin
      last_errors++;
      $display("Mismatch frame %0d bin %0d out_last: got %h, expected %h",
               frame, bin, got, expected);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d sample, %0d last flag, %0d other",
             sample_errors, last_errors, other_errors);
  endtask

  // ************************************************************
  // input and output sides
  // ************************************************************

  task automatic send_frame(input int r);
    int   n;
    logic taken;
    n = 0;
    while (n < N) begin
      in_re  = sample_t'(tab_in_re[r][W*n +: W]);
      in_im  = sample_t'(tab_in_im[r][W*n +: W]);
      in_val = 1'b1;
      @(negedge clk);
      taken = in_rdy;
      if (taken && n == N - 1)
        last_in_cycle[r] = cycle;
      @(posedge clk);
      #(DLY);
      if (taken)
        n++;
    end
  endtask

  task automatic send_all_frames();
    for (int r = 0; r < nrows; r++) begin
      send_frame(r);
    end
    in_val = 1'b0;
  endtask

  task automatic receive_all_frames();
    int bin;
    bin       = 0;
    out_frame = 0;
    while (out_frame < nrows) begin
      @(negedge clk);
      if (out_val && out_rdy) begin
        if (bin == 0 && out_frame < first_stall
            && cycle - last_in_cycle[out_frame] != LATENCY) begin
          other_errors++;
          $display("frame %0d: first output %0d cycles after its last input, expected %0d",
                   out_frame, cycle - last_in_cycle[out_frame], LATENCY);
        end
        check_sample(out_frame, bin, out_re, out_im,
                     sample_t'(tab_exp_re[out_frame][W*bin +: W]),
                     sample_t'(tab_exp_im[out_frame][W*bin +: W]));
        check_last(out_frame, bin, out_last, bin == N - 1);
        bin++;
        if (bin == N) begin
          bin = 0;
          out_frame++;
        end
      end
    end
  endtask

  // random out_rdy only while a stall row is leaving
  initial begin : ready_driver
    forever begin
      @(posedge clk);
      #(DLY);
      if (out_frame < nrows && tab_stall[out_frame])
        out_rdy = lfsr_bit();
      else
        out_rdy = 1'b1;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge clk);
    $display("timeout after %0d cycles, stuck in output frame %0d", WATCHDOG, out_frame);
    report_counts();
    $display("Verification failed");
    $finish;
  end

  initial begin
    in_re         = '0;
    in_im         = '0;
    in_val        = 1'b0;
    out_rdy       = 1'b0;
    sample_errors = 0;
    last_errors   = 0;
    other_errors  = 0;
    build_table();
    wait (rst_n === 1'b1);
    if (in_rdy !== 1'b1) begin
      other_errors++;
      $display("in_rdy is not high after reset");
    end
    fork
      send_all_frames();
      receive_all_frames();
    join
    repeat (10) begin // no extra samples
      @(negedge clk);
      if (out_val !== 1'b0) begin
        other_errors++;
        $display("out_val high after the last expected sample");
      end
    end
    report_counts();
    if (sample_errors + last_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/fft_pkg.sv
fft/fft_crossbar.sv
fft/fft_butterfly_stage.sv
fft/fft_core.sv
logic/bit_reverse_loader.sv
logic/frame_serializer.sv
logic/fft_top.sv
bench/tb_clock_gen.sv
bench/fft_top_assert.sv
bench/tb_fft_top.sv
